//--- list.f
logic/fpu_pkg.sv
logic/fpu_ctrl_regs.sv
logic/fp_align_add.sv
logic/fp_norm_round.sv
logic/fpu_top.sv
verification/tb_clk_gen.sv
verification/tb_fpu_top.sv

//--- run_sim.sh
#!/bin/sh
# build the fpu testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert --top-module tb_fpu_top -f list.f -o tb_fpu_top \
   > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_fpu_top > sim.log 2>&1
cat sim.log

grep -qx "Simulation passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- verification/fpu_stim.txt
// funct7 frm operand1 operand2 expected_result expected_flags flags_clr (all hex)
// flags: 10 nv, 08 dz, 04 of, 02 uf, 01 nx
00 0 3f800000 3f800000 40000000 00 0
00 0 3fc00000 40100000 40700000 00 0
04 0 40400000 3f800000 40000000 00 0
04 0 3f800000 40000000 bf800000 00 0
00 0 c0000000 3f800000 bf800000 00 0
04 0 3f800001 3f800000 34000000 00 0
04 0 3fc00000 3fa00000 3e800000 00 0
04 0 3f800000 3f7fffff 33800000 00 0
00 0 3f800000 3dcccccd 3f8ccccd 01 0
00 0 3f800000 33800000 3f800000 01 0
00 1 3f800000 33800000 3f800000 01 0
00 2 3f800000 33800000 3f800000 01 0
00 3 3f800000 33800000 3f800001 01 0
00 4 3f800000 33800000 3f800001 01 0
00 2 bf800000 b3800000 bf800001 01 0
00 3 bf800000 b3800000 bf800000 01 0
00 4 bf800000 b3800000 bf800001 01 0
00 0 3f800001 33800000 3f800002 01 0
00 0 3f800000 33c00000 3f800001 01 0
04 0 3f800000 3f800000 00000000 00 0
04 2 3f800000 3f800000 80000000 00 0
00 0 00000000 80000000 00000000 00 1
00 2 00000000 80000000 80000000 00 0
00 0 80000000 80000000 80000000 00 0
00 0 00400000 3f800000 3f800000 00 0
04 0 00000001 80400000 00000000 00 0
00 0 7f800000 3f800000 7f800000 00 0
04 0 3f800000 7f800000 ff800000 00 0
00 0 7fc00001 3f800000 7fc00000 00 0
04 0 7f800000 7f800000 7fc00000 10 0
00 0 3f800000 7f800001 7fc00000 10 0
01 0 3f800000 3f800000 7fc00000 10 0
00 5 3f800000 3f800000 7fc00000 10 0
04 7 3f800000 3f800000 7fc00000 10 0
00 0 7f7fffff 7f7fffff 7f800000 05 0
00 1 7f7fffff 7f7fffff 7f7fffff 05 0
00 2 ff7fffff ff7fffff ff800000 05 0
00 3 ff7fffff ff7fffff ff7fffff 05 0
00 0 7f7fffff 73000000 7f800000 05 0
00 1 7f7fffff 73000000 7f7fffff 01 0
04 0 00c00000 00800000 00000000 03 0
04 0 80c00000 80800000 80000000 03 0
00 0 40000000 40000000 40800000 00 0
04 0 40800000 3f800000 40400000 00 1

//--- verification/tb_fpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_fpu_top;

   import fpu_pkg::*;

   localparam int COLS       = 7;       // words per stimulus line
   localparam int MAX_VECS   = 64;
   localparam int LATENCY    = 2;       // falling edges from drive to result
   localparam int RESET_WAIT = 20;      // falling edges allowed for reset release
   localparam int RUN_LIMIT  = 2000;    // watchdog, in clock periods

   // one expected response
   typedef struct packed {
      logic [31:0] res;
      fflags_t     flags;
   } expect_t;

   logic        clk;
   logic        arst_n;
   logic [31:0] floating_point1;
   logic [31:0] floating_point2;
   logic [2:0]  frm;
   logic [6:0]  funct7;
   logic        flags_clr;
   logic [31:0] floating_point_out;
   fflags_t     flags;
   fflags_t     fflags;

   logic [31:0] stim_mem [0:COLS*MAX_VECS-1];
   expect_t     exp_q[$];               // in flight, oldest first
   int          num_vecs;
   int          errors;
   logic        run_done;

   tb_clk_gen u_clk_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   fpu_top UUT (
      .clk                (clk),
      .arst_n             (arst_n),
      .floating_point1    (floating_point1),
      .floating_point2    (floating_point2),
      .frm                (frm),
      .funct7             (funct7),
      .flags_clr          (flags_clr),
      .floating_point_out (floating_point_out),
      .flags              (flags),
      .fflags             (fflags)
   );

   task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
      if (got !== want) begin
         errors++;
         $display("Mismatch %s: got %h, expected %h", name, got, want);
      end
   endtask

   // +0 + +0, add, rne: zero result, no flags
   task automatic drive_idle();
      funct7          = 7'd0;
      frm             = 3'd0;
      floating_point1 = 32'd0;
      floating_point2 = 32'd0;
      flags_clr       = 1'b0;
   endtask

   task automatic drive_vec(input int v);
      int base;
      base            = v * COLS;
      funct7          = stim_mem[base][6:0];
      frm             = stim_mem[base+1][2:0];
      floating_point1 = stim_mem[base+2];
      floating_point2 = stim_mem[base+3];
      flags_clr       = stim_mem[base+6][0];
   endtask

   // first line whose funct7 word is still fill ends the list
   function automatic int count_vecs();
      int n;
      n = 0;
      while (n < MAX_VECS && stim_mem[n * COLS] <= 32'h7f) begin
         n++;
      end
      return n;
   endfunction

   task automatic run_vectors();
      expect_t e;
      fflags_t sticky_model;            // expected fflags
      fflags_t flags_model;             // expected flags before this edge
      logic    clr_last;                // clear pulse seen by the last edge
      string   tag;
      sticky_model = '0;
      flags_model  = '0;
      clr_last     = 1'b0;
      for (int i = 0; i < num_vecs + LATENCY + 2; i++) begin
         @(negedge clk);
         if (clr_last) begin
            sticky_model = '0;          // clear beats arriving flags
         end else begin
            sticky_model = fflags_t'(sticky_model | flags_model);
         end
         if (exp_q.size() == LATENCY) begin
            e = exp_q.pop_front();
         end else begin
            e = '0;                     // reset and idle cycles
         end
         flags_model = e.flags;
         tag = $sformatf("(cycle %0d)", i);
         check_val({"floating_point_out ", tag}, floating_point_out, e.res);
         check_val({"flags ", tag}, {27'd0, flags}, {27'd0, e.flags});
         check_val({"fflags ", tag}, {27'd0, fflags}, {27'd0, sticky_model});
         if (i < num_vecs) begin
            drive_vec(i);
            e.res   = stim_mem[i*COLS+4];
            e.flags = fflags_t'(stim_mem[i*COLS+5][4:0]);
         end else begin
            drive_idle();               // drain the pipeline
            e = '0;
         end
         exp_q.push_back(e);
         clr_last = flags_clr;
      end
   endtask

   initial begin
      int wait_cnt;
      errors   = 0;
      run_done = 1'b0;
      drive_idle();
      for (int a = 0; a < COLS * MAX_VECS; a++) begin
         stim_mem[a] = ~a;              // inverted address, never a valid funct7
      end
      $readmemh("verification/fpu_stim.txt", stim_mem);
      num_vecs = count_vecs();
      if (num_vecs == 0) begin
         errors++;
         $display("No stimulus vectors were read from the data file");
      end
      wait_cnt = 0;
      while (arst_n !== 1'b1 && wait_cnt < RESET_WAIT) begin
         @(negedge clk);
         wait_cnt++;
         if (arst_n === 1'b0) begin
            check_val("floating_point_out (reset)", floating_point_out, 32'd0);
            check_val("flags (reset)", {27'd0, flags}, 32'd0);
            check_val("fflags (reset)", {27'd0, fflags}, 32'd0);
         end
      end
      if (arst_n !== 1'b1) begin
         $display("Reset was never released within %0d cycles", RESET_WAIT);
         $display("Simulation failed");
      end else begin
         run_vectors();
         run_done = 1'b1;
         $display("Checks done over %0d vectors, errors: %0d", num_vecs, errors);
         if (errors == 0) begin
            $display("Simulation passed");
         end else begin
            $display("Simulation failed");
         end
      end
      $finish;
   end

   // stops a run that never reaches the end
   initial begin
      int t;
      t = 0;
      while (!run_done && t < RUN_LIMIT) begin
         #10;
         t++;
      end
      if (!run_done) begin
         $display("Timeout: the run did not finish within %0d clock periods", RUN_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
   output logic clk,
   output logic arst_n
);

   localparam int RESET_CYCLES = 3;     // rising edges under reset

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;            // 10 ns period
   end

   // release lands between edges, away from the flops
   initial begin
      arst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n <= 1'b1;
   end

endmodule

`default_nettype wire

//--- logic/fpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module fpu_top (
   input  wire logic          clk,
   input  wire logic          arst_n,
   input  wire logic [31:0]   floating_point1,   // operand a
   input  wire logic [31:0]   floating_point2,   // operand b
   input  wire logic [2:0]    frm,               // rounding mode
   input  wire logic [6:0]    funct7,            // add or sub
   input  wire logic          flags_clr,         // clears sticky flags
   output logic [31:0]        floating_point_out,
   output fpu_pkg::fflags_t   flags,             // flags of this result
   output fpu_pkg::fflags_t   fflags             // sticky flags
);

   import fpu_pkg::*;

   fp_op_t       op;                    // decoded this cycle
   align_stage_t stage;                 // pipeline register between stages

   // decode and sticky flags
   fpu_ctrl_regs u_ctrl (
      .clk       (clk),
      .arst_n    (arst_n),
      .funct7    (funct7),
      .frm       (frm),
      .flags     (flags),
      .flags_clr (flags_clr),
      .op        (op),
      .fflags    (fflags)
   );

   // stage 1
   fp_align_add u_align (
      .clk    (clk),
      .arst_n (arst_n),
      .op     (op),
      .a      (floating_point1),
      .b      (floating_point2),
      .stage  (stage)
   );

   // stage 2
   fp_norm_round u_round (
      .clk                (clk),
      .arst_n             (arst_n),
      .stage              (stage),
      .floating_point_out (floating_point_out),
      .flags              (flags)
   );

endmodule

`default_nettype wire

//--- logic/fp_norm_round.sv
`timescale 1ns/10ps
`default_nettype none

module fp_norm_round (
   input  wire logic                  clk,
   input  wire logic                  arst_n,
   input  wire fpu_pkg::align_stage_t stage,
   output logic [31:0]                floating_point_out,
   output fpu_pkg::fflags_t           flags
);

   import fpu_pkg::*;

   logic [4:0]        lzc;              // leading zeros below the carry bit
   logic [26:0]       norm_sig;         // hidden bit at 26
   logic signed [9:0] norm_exp;
   logic              lsb;
   logic              guard;
   logic              round_b;
   logic              sticky;
   logic              inexact;
   logic              round_up;
   logic [24:0]       mant;             // rounded significand, bit 24 is carry out
   logic signed [9:0] final_exp;
   logic [22:0]       final_frac;
   logic              to_max;           // overflow saturates to max finite
   logic [31:0]       result;
   fflags_t           result_flags;

   // count from the hidden position downward
   function automatic logic [4:0] lead_zeros(input logic [26:0] v);
      logic [4:0] n;
      logic       hit;
      n   = 5'd0;
      hit = 1'b0;
      for (int i = 26; i >= 0; i--) begin
         if (v[i]) begin
            hit = 1'b1;
         end else if (!hit) begin
            n = n + 5'd1;
         end
      end
      return n;                         // 27 for an all zero input
   endfunction

   assign lzc = lead_zeros(stage.sig[26:0]);

   // normalization
   always_comb begin
      if (stage.sig[27]) begin
         norm_sig = {stage.sig[27:2], stage.sig[1] | stage.sig[0]};  // keep sticky
         norm_exp = stage.exp + 10'sd1;
      end else begin
         norm_sig = stage.sig[26:0] << lzc;  // after cancellation
         norm_exp = stage.exp - $signed({5'd0, lzc});
      end
   end

   assign lsb     = norm_sig[3];
   assign guard   = norm_sig[2];
   assign round_b = norm_sig[1];
   assign sticky  = norm_sig[0];
   assign inexact = guard | round_b | sticky;

   // round increment per mode
   always_comb begin
      case (stage.rm)
         rm_rne:  round_up = guard & (round_b | sticky | lsb);  // tie goes to even
         rm_rtz:  round_up = 1'b0;
         rm_rdn:  round_up = stage.sign & inexact;
         rm_rup:  round_up = !stage.sign & inexact;
         rm_rmm:  round_up = guard;                         // tie goes away
         default: round_up = 1'b0;
      endcase
   end

   assign mant       = {1'b0, norm_sig[26:3]} + {24'd0, round_up};
   assign final_exp  = mant[24] ? (norm_exp + 10'sd1) : norm_exp;  // 1.11..1 rounded up
   assign final_frac = mant[24] ? mant[23:1] : mant[22:0];

   assign to_max = (stage.rm == rm_rtz)
                || ((stage.rm == rm_rdn) && !stage.sign)
                || ((stage.rm == rm_rup) && stage.sign);

   // result select
   always_comb begin
      result_flags = '0;
      if (stage.special) begin
         result          = stage.special_word;  // bypasses rounding
         result_flags.nv = stage.special_nv;
      end else if (stage.sig == 28'd0) begin
         result = {stage.rm == rm_rdn, 31'd0};  // exact zero, -0 only rounding down
      end else if (norm_exp < 10'sd1) begin
         result          = {stage.sign, 31'd0}; // too small, flush
         result_flags.uf = 1'b1;
         result_flags.nx = 1'b1;
      end else if (final_exp > 10'sd254) begin
         result          = to_max ? {stage.sign, 8'hfe, 23'h7f_ffff}
                                  : {stage.sign, 8'hff, 23'd0};
         result_flags.of = 1'b1;
         result_flags.nx = 1'b1;
      end else begin
         result          = {stage.sign, final_exp[7:0], final_frac};
         result_flags.nx = inexact;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         floating_point_out <= 32'd0;
         flags              <= '0;
      end else begin
         floating_point_out <= result;
         flags              <= result_flags;
      end
   end

   // rounding can make infinity but never a nan
   a_no_nan_from_round: assert property (@(posedge clk) disable iff (!arst_n)
      !stage.special |=> !((floating_point_out[30:23] == 8'hff)
                           && (floating_point_out[22:0] != 23'd0)));

endmodule

`default_nettype wire

//--- logic/fp_align_add.sv
`timescale 1ns/10ps
`default_nettype none

module fp_align_add (
   input  wire logic                clk,
   input  wire logic                arst_n,
   input  wire fpu_pkg::fp_op_t     op,
   input  wire fpu_pkg::fp32_u      a,
   input  wire fpu_pkg::fp32_u      b,
   output fpu_pkg::align_stage_t    stage
);

   import fpu_pkg::*;

   logic        sign_a, sign_b;         // sign_b after the subtract flip
   logic        zero_a, zero_b;         // includes flushed subnormals
   logic        inf_a, inf_b;
   logic        nan_a, nan_b;
   logic        snan_a, snan_b;
   logic [23:0] sig_a, sig_b;           // hidden bit + frac
   logic [30:0] mag_a, mag_b;           // for magnitude ordering
   logic        swap;                   // b is the larger one
   logic [7:0]  exp_big, exp_small;
   logic [23:0] sig_big, sig_small;
   logic [7:0]  exp_diff;
   logic [4:0]  shamt;                  // clamped align shift
   logic [53:0] small_wide;             // shifted value plus lost bits
   logic [27:0] big_ext, small_ext;
   logic        eff_sub;                // signs differ after flip
   logic [27:0] sum;
   logic        sign_res;
   logic        zero_sign;              // sign of zero + zero
   logic        special;
   logic [31:0] special_word;
   logic        special_nv;

   // classification
   assign sign_a = a.fields.sign;
   assign sign_b = b.fields.sign ^ op.sub;
   assign zero_a = (a.fields.exp == 8'd0);  // subnormal reads as zero
   assign zero_b = (b.fields.exp == 8'd0);
   assign inf_a  = (a.fields.exp == 8'hff) && (a.fields.frac == 23'd0);
   assign inf_b  = (b.fields.exp == 8'hff) && (b.fields.frac == 23'd0);
   assign nan_a  = (a.fields.exp == 8'hff) && (a.fields.frac != 23'd0);
   assign nan_b  = (b.fields.exp == 8'hff) && (b.fields.frac != 23'd0);
   assign snan_a = nan_a && !a.fields.frac[22];  // quiet bit clear
   assign snan_b = nan_b && !b.fields.frac[22];

   assign sig_a = zero_a ? 24'd0 : {1'b1, a.fields.frac};
   assign sig_b = zero_b ? 24'd0 : {1'b1, b.fields.frac};
   assign mag_a = zero_a ? 31'd0 : a.raw[30:0];
   assign mag_b = zero_b ? 31'd0 : b.raw[30:0];

   // order by magnitude
   assign swap      = (mag_b > mag_a);
   assign exp_big   = swap ? b.fields.exp : a.fields.exp;
   assign exp_small = swap ? a.fields.exp : b.fields.exp;
   assign sig_big   = swap ? sig_b : sig_a;
   assign sig_small = swap ? sig_a : sig_b;
   assign sign_res  = swap ? sign_b : sign_a;

   // alignment, everything past 27 places lands in sticky
   assign exp_diff   = exp_big - exp_small;
   assign shamt      = (exp_diff > 8'd27) ? 5'd27 : exp_diff[4:0];
   assign small_wide = {sig_small, 3'b000, 27'd0} >> shamt;
   assign small_ext  = {1'b0, small_wide[53:27]} | {27'd0, |small_wide[26:0]};
   assign big_ext    = {1'b0, sig_big, 3'b000};

   assign eff_sub = sign_a ^ sign_b;
   assign sum     = eff_sub ? (big_ext - small_ext) : (big_ext + small_ext);

   // x + x keeps the sign, x - x follows the mode
   assign zero_sign = (sign_a == sign_b) ? sign_a : (op.rm == rm_rdn);

   // special results, in priority order
   always_comb begin
      special      = 1'b1;
      special_nv   = 1'b0;
      special_word = CANON_NAN;
      if (op.invalid) begin
         special_nv = 1'b1;
      end else if (nan_a || nan_b) begin
         special_nv = snan_a || snan_b;         // quiet nan raises nothing
      end else if (inf_a && inf_b && eff_sub) begin
         special_nv = 1'b1;                     // inf - inf
      end else if (inf_a) begin
         special_word = {sign_a, 8'hff, 23'd0};
      end else if (inf_b) begin
         special_word = {sign_b, 8'hff, 23'd0};
      end else if (zero_a && zero_b) begin
         special_word = {zero_sign, 31'd0};
      end else begin
         special = 1'b0;                        // ordinary sum
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         stage <= '0;
      end else begin
         stage.sign         <= sign_res;
         stage.exp          <= {2'b00, exp_big};
         stage.sig          <= sum;
         stage.rm           <= op.rm;
         stage.special      <= special;
         stage.special_word <= special_word;
         stage.special_nv   <= special_nv;
      end
   end

   // an ordinary sum always carries the larger operand's nonzero exponent
   a_no_zero_exp_overflow: assert property (@(posedge clk) disable iff (!arst_n)
      (!stage.special && (stage.exp == 10'sd0)) |-> (stage.sig[27:26] != 2'b11));

endmodule

`default_nettype wire

//--- logic/fpu_ctrl_regs.sv
`timescale 1ns/10ps
`default_nettype none

module fpu_ctrl_regs (
   input  wire logic             clk,
   input  wire logic             arst_n,
   input  wire logic [6:0]       funct7,
   input  wire logic [2:0]       frm,
   input  wire fpu_pkg::fflags_t flags,      // registered flags of stage 2
   input  wire logic             flags_clr,  // one cycle clear pulse
   output fpu_pkg::fp_op_t       op,
   output fpu_pkg::fflags_t      fflags      // sticky accumulated flags
);

   import fpu_pkg::*;

   localparam logic [6:0] F7_ADD = 7'b000_0000;
   localparam logic [6:0] F7_SUB = 7'b000_0100;

   logic f7_ok;                              // known opcode
   logic rm_ok;                              // frm inside the five modes

   assign f7_ok = (funct7 == F7_ADD) || (funct7 == F7_SUB);
   assign rm_ok = (frm <= 3'd4);

   // opcode and mode decode, pure combinational
   always_comb begin
      op.sub     = (funct7 == F7_SUB);
      op.rm      = rm_ok ? rm_e'(frm) : rm_rne;  // reserved codes never pass through
      op.invalid = !f7_ok || !rm_ok;
   end

   // sticky flags, clear beats arriving flags
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fflags <= '0;
      end else if (flags_clr) begin
         fflags <= '0;                         // arriving flags dropped
      end else begin
         fflags <= fflags_t'(fflags | flags);  // accumulate
      end
   end

   // nothing in the add path can raise divide by zero
   a_dz_never_set: assert property (@(posedge clk) disable iff (!arst_n)
      !fflags.dz);

endmodule

`default_nettype wire

//--- logic/fpu_pkg.sv
`default_nettype none

package fpu_pkg;

   localparam logic [31:0] CANON_NAN = 32'h7fc0_0000;  // the only nan ever produced

   // one operand word, read whole or by field
   typedef struct packed {
      logic        sign;
      logic [7:0]  exp;                 // biased by 127, 0 means zero here
      logic [22:0] frac;                // frac[22] set marks a quiet nan
   } fp32_fields_t;

   typedef union packed {
      logic [31:0]  raw;                // word as it sits on the bus
      fp32_fields_t fields;             // same bits, classified
   } fp32_u;

   typedef enum logic [2:0] {
      rm_rne = 3'd0,                    // nearest, ties to even
      rm_rtz = 3'd1,                    // toward zero
      rm_rdn = 3'd2,                    // toward -inf
      rm_rup = 3'd3,                    // toward +inf
      rm_rmm = 3'd4                     // nearest, ties away from zero
   } rm_e;                              // 5..7 reserved

   // decoded operation for this cycle
   typedef struct packed {
      logic sub;                        // flip sign of b
      rm_e  rm;
      logic invalid;                    // bad funct7 or reserved frm
   } fp_op_t;

   // exception flags, msb first as in the flag csr
   typedef struct packed {
      logic nv;                         // invalid operation
      logic dz;                         // divide by zero, never set by add/sub
      logic of;                         // overflow
      logic uf;                         // underflow
      logic nx;                         // inexact
   } fflags_t;

   // stage 1 to stage 2 register
   typedef struct packed {
      logic              sign;          // sign of the larger operand
      logic signed [9:0] exp;           // room for renormalization
      logic [27:0]       sig;           // carry, hidden, frac, g, r, s
      rm_e               rm;
      logic              special;       // result already known
      logic [31:0]       special_word;
      logic              special_nv;
   } align_stage_t;

endpackage

`default_nettype wire
